//--- bram_axi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

// Fixed latency: with the handshake at edge N, the RAM access happens in the
// cycle after N and bvalid/rvalid are high after edge N+1.
module bram_axi_ctrl (
	input  logic                           clk,
	input  logic                           arst_n,

	input  logic [`MEM_AXI_ADDR_W-1:0]     awaddr,
	input  logic                           awvalid,
	output logic                           awready,

	input  logic [`MEM_DATA_W-1:0]         wdata,
	input  logic [`MEM_DATA_W/8-1:0]       wstrb,
	input  logic                           wvalid,
	output logic                           wready,

	output mem_pkg::axi_resp_e             bresp,
	output logic                           bvalid,
	input  logic                           bready,

	input  logic [`MEM_AXI_ADDR_W-1:0]     araddr,
	input  logic                           arvalid,
	output logic                           arready,

	output logic [`MEM_DATA_W-1:0]         rdata,
	output mem_pkg::axi_resp_e             rresp,
	output logic                           rvalid,
	input  logic                           rready,

	output logic                           bram_en,
	output logic [`MEM_DATA_W/8-1:0]       bram_we,
	output logic [`MEM_IDX_W-1:0]          bram_idx,
	output logic [`MEM_DATA_W-1:0]         bram_wrdata,
	input  logic [`MEM_DATA_W-1:0]         bram_rddata
);

	import mem_pkg::*;

	ctrl_state_e state;
	logic        wr_pair;
	logic        wr_ok;
	logic        rd_ok;
	logic        err;

	// a write is only taken with its data
	assign wr_pair = awvalid && wvalid;

	// bits 1:0 are ignored, anything at or above MEM_WORDS words is an error
	assign wr_ok = awaddr[`MEM_AXI_ADDR_W-1:2] < `MEM_WORDS;
	assign rd_ok = araddr[`MEM_AXI_ADDR_W-1:2] < `MEM_WORDS;

	assign awready = (state == ST_IDLE) && wr_pair;
	assign wready  = awready;
	// write pair wins over a pending read
	assign arready = (state == ST_IDLE) && arvalid && !wr_pair;

	assign bresp = err ? RESP_SLVERR : RESP_OKAY;
	assign rresp = err ? RESP_SLVERR : RESP_OKAY;

	// RAM output register holds while en stays low, so rdata is stable under back-pressure
	assign rdata = err ? '0 : bram_rddata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_IDLE;
			bram_en <= 1'b0;
			bram_we <= '0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (awready) begin
						bram_en <= wr_ok;
						bram_we <= wr_ok ? wstrb : '0;
						state   <= ST_WRITE;
					end else if (arready) begin
						bram_en <= rd_ok;
						bram_we <= '0;
						state   <= ST_READ;
					end
				end
				ST_WRITE: begin
					// RAM takes the write at this edge
					bram_en <= 1'b0;
					bram_we <= '0;
					bvalid  <= 1'b1;
					state   <= ST_BRESP;
				end
				ST_BRESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				ST_READ: begin
					bram_en <= 1'b0;
					rvalid  <= 1'b1;
					state   <= ST_RDATA;
				end
				ST_RDATA: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				default: begin
					bram_en <= 1'b0;
					bram_we <= '0;
					bvalid  <= 1'b0;
					rvalid  <= 1'b0;
					state   <= ST_IDLE;
				end
			endcase
		end
	end

	// address, data and error flag, loaded at the handshake
	always_ff @(posedge clk) begin
		if (awready) begin
			bram_idx    <= awaddr[`MEM_IDX_W+1:2];
			bram_wrdata <= wdata;
			err         <= !wr_ok;
		end else if (arready) begin
			bram_idx <= araddr[`MEM_IDX_W+1:2];
			err      <= !rd_ok;
		end
	end

	a_one_response: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(bvalid && rvalid)
	);

	// response and its code are held until the master takes them
	a_bvalid_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp)
	);

	a_we_needs_en: assert property (
		@(posedge clk) disable iff (!arst_n)
		(bram_we != '0) |-> bram_en
	);

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
mem_pkg.sv
bram_axi_ctrl.sv
dual_port_ram.sv
mem_top.sv
tb_clock_gen.sv
mem_top_tb.sv

//--- dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module dual_port_ram (
	input  logic                       clk,
	input  logic                       arst_n,

	input  logic                       en_a,
	input  logic                       en_b,
	input  logic [`MEM_DATA_W/8-1:0]   we_a,
	input  logic [`MEM_DATA_W/8-1:0]   we_b,
	input  logic [`MEM_IDX_W-1:0]      idx_a,
	input  logic [`MEM_IDX_W-1:0]      idx_b,
	input  logic [`MEM_DATA_W-1:0]     wrdata_a,
	input  logic [`MEM_DATA_W-1:0]     wrdata_b,
	output logic [`MEM_DATA_W-1:0]     rddata_a,
	output logic [`MEM_DATA_W-1:0]     rddata_b
);

	logic [`MEM_DATA_W-1:0] mem [`MEM_WORDS];

	// port b loses only the lanes that port a writes in the same cycle
	always_ff @(posedge clk) begin
		for (int i = 0; i < `MEM_DATA_W/8; i++) begin
			if (en_a && we_a[i])
				mem[idx_a][8*i +: 8] <= wrdata_a[8*i +: 8];
			if (en_b && we_b[i] && !(en_a && we_a[i] && idx_a == idx_b))
				mem[idx_b][8*i +: 8] <= wrdata_b[8*i +: 8];
		end
	end

	// read-before-write on both ports
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rddata_a <= '0;
			rddata_b <= '0;
		end else begin
			if (en_a)
				rddata_a <= mem[idx_a];
			if (en_b)
				rddata_b <= mem[idx_b];
		end
	end

	a_idx_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		(en_a && we_a != '0 |-> idx_a < `MEM_WORDS) and
		(en_b && we_b != '0 |-> idx_b < `MEM_WORDS)
	);

endmodule

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

	// one outstanding transaction per port
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_WRITE = 3'd1,
		ST_BRESP = 3'd2,
		ST_READ  = 3'd3,
		ST_RDATA = 3'd4
	} ctrl_state_e;

	// only the two codes this slave can return
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

endpackage

`default_nettype wire

//--- mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data path width of both AXI ports and the RAM
`define MEM_DATA_W 32

// byte address width seen by each controller
`define MEM_AXI_ADDR_W 16

// 4 KiB of storage, shared by imem and dmem
`define MEM_WORDS 1024

// word index into the array
`define MEM_IDX_W 10

`endif

//--- mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_top (
	input  logic                           clk,
	input  logic                           arst_n,

	// instruction port
	input  logic [`MEM_AXI_ADDR_W-1:0]     imem_awaddr,
	input  logic                           imem_awvalid,
	output logic                           imem_awready,
	input  logic [`MEM_DATA_W-1:0]         imem_wdata,
	input  logic [`MEM_DATA_W/8-1:0]       imem_wstrb,
	input  logic                           imem_wvalid,
	output logic                           imem_wready,
	output mem_pkg::axi_resp_e             imem_bresp,
	output logic                           imem_bvalid,
	input  logic                           imem_bready,
	input  logic [`MEM_AXI_ADDR_W-1:0]     imem_araddr,
	input  logic                           imem_arvalid,
	output logic                           imem_arready,
	output logic [`MEM_DATA_W-1:0]         imem_rdata,
	output mem_pkg::axi_resp_e             imem_rresp,
	output logic                           imem_rvalid,
	input  logic                           imem_rready,

	// data port
	input  logic [`MEM_AXI_ADDR_W-1:0]     dmem_awaddr,
	input  logic                           dmem_awvalid,
	output logic                           dmem_awready,
	input  logic [`MEM_DATA_W-1:0]         dmem_wdata,
	input  logic [`MEM_DATA_W/8-1:0]       dmem_wstrb,
	input  logic                           dmem_wvalid,
	output logic                           dmem_wready,
	output mem_pkg::axi_resp_e             dmem_bresp,
	output logic                           dmem_bvalid,
	input  logic                           dmem_bready,
	input  logic [`MEM_AXI_ADDR_W-1:0]     dmem_araddr,
	input  logic                           dmem_arvalid,
	output logic                           dmem_arready,
	output logic [`MEM_DATA_W-1:0]         dmem_rdata,
	output mem_pkg::axi_resp_e             dmem_rresp,
	output logic                           dmem_rvalid,
	input  logic                           dmem_rready
);

	import mem_pkg::*;

	logic                       bram_en_a;
	logic [`MEM_DATA_W/8-1:0]   bram_we_a;
	logic [`MEM_IDX_W-1:0]      bram_idx_a;
	logic [`MEM_DATA_W-1:0]     bram_wrdata_a;
	logic [`MEM_DATA_W-1:0]     bram_rddata_a;

	logic                       bram_en_b;
	logic [`MEM_DATA_W/8-1:0]   bram_we_b;
	logic [`MEM_IDX_W-1:0]      bram_idx_b;
	logic [`MEM_DATA_W-1:0]     bram_wrdata_b;
	logic [`MEM_DATA_W-1:0]     bram_rddata_b;

	// imem on port a, so it wins write collisions
	bram_axi_ctrl imem_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.awaddr      (imem_awaddr),
		.awvalid     (imem_awvalid),
		.awready     (imem_awready),
		.wdata       (imem_wdata),
		.wstrb       (imem_wstrb),
		.wvalid      (imem_wvalid),
		.wready      (imem_wready),
		.bresp       (imem_bresp),
		.bvalid      (imem_bvalid),
		.bready      (imem_bready),
		.araddr      (imem_araddr),
		.arvalid     (imem_arvalid),
		.arready     (imem_arready),
		.rdata       (imem_rdata),
		.rresp       (imem_rresp),
		.rvalid      (imem_rvalid),
		.rready      (imem_rready),
		.bram_en     (bram_en_a),
		.bram_we     (bram_we_a),
		.bram_idx    (bram_idx_a),
		.bram_wrdata (bram_wrdata_a),
		.bram_rddata (bram_rddata_a)
	);

	bram_axi_ctrl dmem_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.awaddr      (dmem_awaddr),
		.awvalid     (dmem_awvalid),
		.awready     (dmem_awready),
		.wdata       (dmem_wdata),
		.wstrb       (dmem_wstrb),
		.wvalid      (dmem_wvalid),
		.wready      (dmem_wready),
		.bresp       (dmem_bresp),
		.bvalid      (dmem_bvalid),
		.bready      (dmem_bready),
		.araddr      (dmem_araddr),
		.arvalid     (dmem_arvalid),
		.arready     (dmem_arready),
		.rdata       (dmem_rdata),
		.rresp       (dmem_rresp),
		.rvalid      (dmem_rvalid),
		.rready      (dmem_rready),
		.bram_en     (bram_en_b),
		.bram_we     (bram_we_b),
		.bram_idx    (bram_idx_b),
		.bram_wrdata (bram_wrdata_b),
		.bram_rddata (bram_rddata_b)
	);

	dual_port_ram ram (
		.clk      (clk),
		.arst_n   (arst_n),
		.en_a     (bram_en_a),
		.en_b     (bram_en_b),
		.we_a     (bram_we_a),
		.we_b     (bram_we_b),
		.idx_a    (bram_idx_a),
		.idx_b    (bram_idx_b),
		.wrdata_a (bram_wrdata_a),
		.wrdata_b (bram_wrdata_b),
		.rddata_a (bram_rddata_a),
		.rddata_b (bram_rddata_b)
	);

endmodule

`default_nettype wire

//--- mem_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_top_tb;

	import mem_pkg::*;

	localparam int DRIVE_DLY = 2;
	localparam int N_TRANS = 142;
	// handshake edge plus the edge where the response rises
	localparam int RESP_EDGES = 2;

	logic clk;
	logic arst_n;

	// index 0 is imem and index 1 is dmem
	logic [`MEM_AXI_ADDR_W-1:0] awaddr [2];
	logic                       awvalid [2];
	logic                       awready [2];
	logic [`MEM_DATA_W-1:0]     wdata [2];
	logic [`MEM_DATA_W/8-1:0]   wstrb [2];
	logic                       wvalid [2];
	logic                       wready [2];
	axi_resp_e                  bresp [2];
	logic                       bvalid [2];
	logic                       bready [2];
	logic [`MEM_AXI_ADDR_W-1:0] araddr [2];
	logic                       arvalid [2];
	logic                       arready [2];
	logic [`MEM_DATA_W-1:0]     rdata [2];
	axi_resp_e                  rresp [2];
	logic                       rvalid [2];
	logic                       rready [2];

	logic [`MEM_DATA_W-1:0] ref_mem [`MEM_WORDS];
	logic [`MEM_IDX_W-1:0]  idx_list [32];
	logic [31:0]            lfsr = 32'h5cab;
	int                     errors = 0;
	int                     checks = 0;
	string                  test_name = "none";

	tb_clock_gen clock_gen (.clk(clk), .arst_n(arst_n));

	mem_top DUT (
		.clk(clk), .arst_n(arst_n),
		.imem_awaddr(awaddr[0]), .imem_awvalid(awvalid[0]), .imem_awready(awready[0]),
		.imem_wdata(wdata[0]), .imem_wstrb(wstrb[0]),
		.imem_wvalid(wvalid[0]), .imem_wready(wready[0]),
		.imem_bresp(bresp[0]), .imem_bvalid(bvalid[0]), .imem_bready(bready[0]),
		.imem_araddr(araddr[0]), .imem_arvalid(arvalid[0]), .imem_arready(arready[0]),
		.imem_rdata(rdata[0]), .imem_rresp(rresp[0]),
		.imem_rvalid(rvalid[0]), .imem_rready(rready[0]),
		.dmem_awaddr(awaddr[1]), .dmem_awvalid(awvalid[1]), .dmem_awready(awready[1]),
		.dmem_wdata(wdata[1]), .dmem_wstrb(wstrb[1]),
		.dmem_wvalid(wvalid[1]), .dmem_wready(wready[1]),
		.dmem_bresp(bresp[1]), .dmem_bvalid(bvalid[1]), .dmem_bready(bready[1]),
		.dmem_araddr(araddr[1]), .dmem_arvalid(arvalid[1]), .dmem_arready(arready[1]),
		.dmem_rdata(rdata[1]), .dmem_rresp(rresp[1]),
		.dmem_rvalid(rvalid[1]), .dmem_rready(rready[1])
	);

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [1:0] exp_resp(input logic [15:0] addr);
		return (addr < 16'h1000) ? RESP_OKAY : RESP_SLVERR;
	endfunction

	// out of range writes leave the array alone
	function automatic void model_write(input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		if (addr < 16'h1000) begin
			for (int i = 0; i < 4; i++) begin
				if (strb[i])
					ref_mem[addr[11:2]][8*i +: 8] = data[8*i +: 8];
			end
		end
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	// entered and left 2 ns after a rising edge
	task automatic axi_write(input int p, input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int stall, output logic [1:0] resp, output int lat);
		int n;
		resp = 2'b11;
		lat = 0;
		n = 0;
		awaddr[p] = addr;
		wdata[p] = data;
		wstrb[p] = strb;
		awvalid[p] = 1'b1;
		wvalid[p] = 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!(awready[p] && wready[p]) && n < 8);
		@(posedge clk);
		#DRIVE_DLY;
		awvalid[p] = 1'b0;
		wvalid[p] = 1'b0;
		if (n >= 8) begin
			errors++;
			$display("%s: no awready/wready within 8 cycles on port %0d", test_name, p);
			return;
		end
		do begin
			@(negedge clk);
			lat++;
		end while (!bvalid[p] && lat < 8);
		if (!bvalid[p]) begin
			errors++;
			$display("%s: no bvalid within 8 cycles on port %0d", test_name, p);
			@(posedge clk);
			#DRIVE_DLY;
			return;
		end
		resp = bresp[p];
		// a read offered while the response waits must not be taken
		for (int i = 0; i < stall; i++) begin
			@(posedge clk);
			#DRIVE_DLY;
			araddr[p] = addr;
			arvalid[p] = 1'b1;
			@(negedge clk);
			check_val("bvalid held", 32'h1, 32'(bvalid[p]));
			check_val("bresp held", 32'(resp), 32'(bresp[p]));
			check_val("arready while busy", 32'h0, 32'(arready[p]));
		end
		@(posedge clk);
		#DRIVE_DLY;
		arvalid[p] = 1'b0;
		bready[p] = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		bready[p] = 1'b0;
	endtask

	task automatic axi_read(input int p, input logic [15:0] addr, input int stall,
			output logic [31:0] data, output logic [1:0] resp, output int lat);
		int n;
		data = '0;
		resp = 2'b11;
		lat = 0;
		n = 0;
		araddr[p] = addr;
		arvalid[p] = 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!arready[p] && n < 8);
		@(posedge clk);
		#DRIVE_DLY;
		arvalid[p] = 1'b0;
		if (n >= 8) begin
			errors++;
			$display("%s: no arready within 8 cycles on port %0d", test_name, p);
			return;
		end
		do begin
			@(negedge clk);
			lat++;
		end while (!rvalid[p] && lat < 8);
		if (!rvalid[p]) begin
			errors++;
			$display("%s: no rvalid within 8 cycles on port %0d", test_name, p);
			@(posedge clk);
			#DRIVE_DLY;
			return;
		end
		data = rdata[p];
		resp = rresp[p];
		for (int i = 0; i < stall; i++) begin
			@(posedge clk);
			#DRIVE_DLY;
			arvalid[p] = 1'b1;
			@(negedge clk);
			check_val("rvalid held", 32'h1, 32'(rvalid[p]));
			check_val("rdata held", data, rdata[p]);
			check_val("rresp held", 32'(resp), 32'(rresp[p]));
			check_val("arready while busy", 32'h0, 32'(arready[p]));
		end
		@(posedge clk);
		#DRIVE_DLY;
		arvalid[p] = 1'b0;
		rready[p] = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		rready[p] = 1'b0;
	endtask

	task automatic write_and_model(input int p, input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int stall);
		logic [1:0] resp;
		int lat;
		axi_write(p, addr, data, strb, stall, resp, lat);
		check_val("bresp", 32'(exp_resp(addr)), 32'(resp));
		check_val("write response edges", RESP_EDGES, lat);
		model_write(addr, data, strb);
	endtask

	task automatic read_and_check(input int p, input logic [15:0] addr, input int stall);
		logic [31:0] d;
		logic [1:0] resp;
		int lat;
		axi_read(p, addr, stall, d, resp, lat);
		check_val("rresp", 32'(exp_resp(addr)), 32'(resp));
		check_val("read response edges", RESP_EDGES, lat);
		check_val("rdata", (exp_resp(addr) == RESP_OKAY) ? ref_mem[addr[11:2]] : 32'h0, d);
	endtask

	task automatic test_reset_idle();
		logic [31:0] d;
		logic [1:0] resp;
		int lat;
		test_name = "test_reset_idle";
		@(negedge clk);
		for (int p = 0; p < 2; p++) begin
			check_val("awready", 32'h0, 32'(awready[p]));
			check_val("wready", 32'h0, 32'(wready[p]));
			check_val("arready", 32'h0, 32'(arready[p]));
			check_val("bvalid", 32'h0, 32'(bvalid[p]));
			check_val("rvalid", 32'h0, 32'(rvalid[p]));
		end
		@(posedge clk);
		#DRIVE_DLY;
		// contents still unwritten so only response and timing
		for (int p = 0; p < 2; p++) begin
			axi_read(p, 16'h0, 0, d, resp, lat);
			check_val("rresp", 32'(RESP_OKAY), 32'(resp));
			check_val("response edges", RESP_EDGES, lat);
		end
	endtask

	task automatic test_cross_port();
		test_name = "test_cross_port";
		for (int i = 0; i < 32; i++) begin
			idx_list[i] = 10'(rand_bits(10));
			write_and_model(1, {4'h0, idx_list[i], 2'(rand_bits(2))}, rand_bits(32), 4'hf, 0);
		end
		for (int i = 0; i < 32; i++) begin
			read_and_check(0, {4'h0, idx_list[i], 2'b00}, 0);
			read_and_check(1, {4'h0, idx_list[i], 2'b00}, 0);
		end
	endtask

	task automatic test_byte_strobe();
		logic [15:0] addr;
		logic [3:0] strb;
		test_name = "test_byte_strobe";
		for (int i = 0; i < 8; i++) begin
			addr = {4'h0, idx_list[i], 2'b00};
			strb = 4'(rand_bits(4));
			if (strb == 4'h0 || strb == 4'hf)
				strb = 4'b0101;
			write_and_model(i % 2, addr, rand_bits(32), strb, 0);
			read_and_check(1 - i % 2, addr, 0);
		end
	endtask

	task automatic test_range_error();
		logic [15:0] addr;
		test_name = "test_range_error";
		for (int i = 0; i < 2; i++) begin
			// same low 12 bits as a word already written
			addr = (i == 0) ? {4'h1, idx_list[2], 2'b00} : {4'hf, idx_list[2], 2'b11};
			write_and_model(1, addr, rand_bits(32), 4'hf, 0);
			read_and_check(0, addr, 0);
			read_and_check(1, {4'h0, idx_list[2], 2'b00}, 0);
		end
	endtask

	task automatic test_collision();
		logic [15:0] addr;
		logic [3:0] sa;
		logic [3:0] sb;
		logic [31:0] da;
		logic [31:0] db;
		logic [1:0] ra;
		logic [1:0] rb;
		int la;
		int lb;
		test_name = "test_collision";
		addr = {4'h0, idx_list[1], 2'b00};
		for (int r = 0; r < 2; r++) begin
			sa = 4'b0011;
			sb = (r == 0) ? 4'b0110 : 4'b1100;
			da = rand_bits(32);
			db = rand_bits(32);
			fork
				axi_write(0, addr, da, sa, 0, ra, la);
				axi_write(1, addr, db, sb, 0, rb, lb);
			join
			check_val("bresp imem", 32'(RESP_OKAY), 32'(ra));
			check_val("bresp dmem", 32'(RESP_OKAY), 32'(rb));
			check_val("write response edges imem", RESP_EDGES, la);
			check_val("write response edges dmem", RESP_EDGES, lb);
			// imem applied last because it owns the shared lanes
			model_write(addr, db, sb);
			model_write(addr, da, sa);
			read_and_check(1, addr, 0);
		end
	endtask

	task automatic test_backpressure();
		logic [15:0] addr;
		test_name = "test_backpressure";
		for (int i = 0; i < 8; i++) begin
			addr = {4'h0, 10'(rand_bits(10)), 2'b00};
			write_and_model(i % 2, addr, rand_bits(32), 4'hf, int'(rand_bits(3)));
			read_and_check(1 - i % 2, addr, int'(rand_bits(3)));
		end
	endtask

	initial begin
		for (int p = 0; p < 2; p++) begin
			awaddr[p] = '0;
			awvalid[p] = 1'b0;
			wdata[p] = '0;
			wstrb[p] = '0;
			wvalid[p] = 1'b0;
			bready[p] = 1'b0;
			araddr[p] = '0;
			arvalid[p] = 1'b0;
			rready[p] = 1'b0;
		end
		wait (arst_n === 1'b1);
		@(posedge clk);
		#DRIVE_DLY;
		test_reset_idle();
		test_cross_port();
		test_byte_strobe();
		test_range_error();
		test_collision();
		test_backpressure();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// about 20 cycles per transaction at most
	initial begin
		repeat (N_TRANS * 20 + 200) @(posedge clk);
		$display("watchdog expired, tests did not finish in time");
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mem_top_tb -f compile.f -o mem_top_sim \
	&& ./obj_dir/mem_top_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^TEST RESULT: PASS$" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset held over two rising edges
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

`default_nettype wire
